// ==== Makefile ====
sim:
	verilator --binary --timing --timescale 1ns/1ps -f filelist.f \
		--top-module tb_ahb_apb_bridge -Mdir obj_dir
	./obj_dir/Vtb_ahb_apb_bridge | tee sim.log
	grep -q "^NO ERRORS$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

// ==== design/ahb_apb_bridge.sv ====
// AHB to APB bridge top

`timescale 1ns/1ps
`default_nettype none

module ahb_apb_bridge
  import ahb_apb_pkg::*;
(
  // AHB slave side
  input  wire                   hclk6,
  input  wire                   hreset_n6,
  input  wire                   hsel,
  input  wire  [addr_width-1:0] haddr,
  input  wire  [1:0]            htrans,
  input  wire                   hwrite,
  input  wire  [data_width-1:0] hwdata,
  output logic                  hready,
  output logic [data_width-1:0] hrdata,

  // APB bus shared by all slaves
  output logic [addr_width-1:0] paddr,
  output logic                  penable,
  output logic                  pwrite,
  output logic [data_width-1:0] pwdata,

  // Per-slave select and response
  output logic                  psel0,
  output logic                  psel1,
  output logic                  psel2,
  output logic                  psel3,
  input  wire                   pready0,
  input  wire                   pready1,
  input  wire                   pready2,
  input  wire                   pready3,
  input  wire  [data_width-1:0] prdata0,
  input  wire  [data_width-1:0] prdata1,
  input  wire  [data_width-1:0] prdata2,
  input  wire  [data_width-1:0] prdata3
);

  logic                  capture;
  logic                  pending;
  logic                  done;
  logic [addr_width-1:0] held_addr;
  logic                  held_write;
  logic [data_width-1:0] held_wdata;
  slave_sel_t            slave_sel;
  logic                  no_hit;
  slave_sel_t            psel;

  // ---------------------------------------------------------------------------
  // AHB side
  // ---------------------------------------------------------------------------
  ahb_transfer_capture i_ahb_transfer_capture (
    .hclk6      (hclk6),
    .hreset_n6  (hreset_n6),
    .hsel       (hsel),
    .haddr      (haddr),
    .htrans     (htrans),
    .hwrite     (hwrite),
    .hwdata     (hwdata),
    .done       (done),
    .hready     (hready),
    .capture    (capture),
    .pending    (pending),
    .held_addr  (held_addr),
    .held_write (held_write),
    .held_wdata (held_wdata)
  );

  // Decode runs alongside capture on the same address phase
  apb_slave_decoder i_apb_slave_decoder (
    .hclk6     (hclk6),
    .hreset_n6 (hreset_n6),
    .capture   (capture),
    .haddr     (haddr),
    .slave_sel (slave_sel),
    .no_hit    (no_hit)
  );

  // ---------------------------------------------------------------------------
  // APB side
  // ---------------------------------------------------------------------------
  apb_sequencer i_apb_sequencer (
    .hclk6      (hclk6),
    .hreset_n6  (hreset_n6),
    .pending    (pending),
    .held_addr  (held_addr),
    .held_write (held_write),
    .held_wdata (held_wdata),
    .slave_sel  (slave_sel),
    .no_hit     (no_hit),
    .pready     ({pready3, pready2, pready1, pready0}),
    .prdata0    (prdata0),
    .prdata1    (prdata1),
    .prdata2    (prdata2),
    .prdata3    (prdata3),
    .psel       (psel),
    .penable    (penable),
    .paddr      (paddr),
    .pwrite     (pwrite),
    .pwdata     (pwdata),
    .hrdata     (hrdata),
    .done       (done)
  );

  // Select vector out to the slave ports
  assign psel0 = psel[0];
  assign psel1 = psel[1];
  assign psel2 = psel[2];
  assign psel3 = psel[3];

endmodule

`default_nettype wire

// ==== design/ahb_apb_pkg.sv ====
// AHB to APB bridge package

`default_nettype none

package ahb_apb_pkg;

  // -------------------------------------------------------------------------
  // Bus widths
  // -------------------------------------------------------------------------
  localparam int addr_width = 32;
  localparam int data_width = 32;
  localparam int num_slaves = 4;

  // -------------------------------------------------------------------------
  // APB address map, inclusive ranges of 4 KB each
  // -------------------------------------------------------------------------
  localparam logic [addr_width-1:0] slave_base [num_slaves] = '{
    32'h0000_1000,
    32'h0000_2000,
    32'h0000_3000,
    32'h0000_4000
  };

  localparam logic [addr_width-1:0] slave_last [num_slaves] = '{
    32'h0000_1fff,
    32'h0000_2fff,
    32'h0000_3fff,
    32'h0000_4fff
  };

  // AHB htrans codes the bridge responds to
  localparam logic [1:0] htrans_nonseq = 2'b10;
  localparam logic [1:0] htrans_seq    = 2'b11;

  // One-hot APB FSM states
  typedef enum logic [2:0] {
    apb_idle   = 3'b001,
    apb_setup  = 3'b010,
    apb_access = 3'b100
  } apb_state_t;

  // One bit per APB slave
  typedef logic [num_slaves-1:0] slave_sel_t;

endpackage

`default_nettype wire

// ==== design/ahb_transfer_capture.sv ====
// AHB transfer capture

`timescale 1ns/1ps
`default_nettype none

`include "bridge_regs.svh"

module ahb_transfer_capture
  import ahb_apb_pkg::*;
(
  input  wire                   hclk6,
  input  wire                   hreset_n6,
  input  wire                   hsel,
  input  wire  [addr_width-1:0] haddr,
  input  wire  [1:0]            htrans,
  input  wire                   hwrite,
  input  wire  [data_width-1:0] hwdata,
  input  wire                   done,
  output logic                  hready,
  output logic                  capture,
  output logic                  pending,
  output logic [addr_width-1:0] held_addr,
  output logic                  held_write,
  output logic [data_width-1:0] held_wdata
);

  // High for the cycle after an accepted address phase
  logic data_phase;

  // ---------------------------------------------------------------------------
  // Address phase acceptance
  // ---------------------------------------------------------------------------

  // Only NONSEQ and SEQ start a transfer, IDLE and BUSY are ignored
  assign capture = hready && hsel &&
                   ((htrans == htrans_nonseq) || (htrans == htrans_seq));

  // A transfer is outstanding whenever the AHB bus is held
  assign pending = ~hready;

  always_ff @(posedge hclk6 or negedge hreset_n6) begin
    if (!hreset_n6) begin
      hready     <= `bridge_rst_ready;
      data_phase <= 1'b0;
    end else begin
      data_phase <= capture;
      if (capture) begin
        hready <= 1'b0;
      end else if (done) begin
        hready <= 1'b1;
      end
    end
  end

  // ---------------------------------------------------------------------------
  // Held transfer
  // ---------------------------------------------------------------------------

  // Address and direction come from the address phase
  always_ff @(posedge hclk6 or negedge hreset_n6) begin
    if (!hreset_n6) begin
      held_addr  <= `bridge_rst_zero;
      held_write <= 1'b0;
    end else if (capture) begin
      held_addr  <= haddr;
      held_write <= hwrite;
    end
  end

  // Write data arrives one cycle later, in the AHB data phase
  always_ff @(posedge hclk6 or negedge hreset_n6) begin
    if (!hreset_n6) begin
      held_wdata <= `bridge_rst_zero;
    end else if (data_phase && held_write) begin
      held_wdata <= hwdata;
    end
  end

endmodule

`default_nettype wire

// ==== design/apb_sequencer.sv ====
// APB transfer sequencer

`timescale 1ns/1ps
`default_nettype none

`include "bridge_regs.svh"

module apb_sequencer
  import ahb_apb_pkg::*;
(
  input  wire                   hclk6,
  input  wire                   hreset_n6,
  input  wire                   pending,
  input  wire  [addr_width-1:0] held_addr,
  input  wire                   held_write,
  input  wire  [data_width-1:0] held_wdata,
  input  wire  slave_sel_t      slave_sel,
  input  wire                   no_hit,
  input  wire  [num_slaves-1:0] pready,
  input  wire  [data_width-1:0] prdata0,
  input  wire  [data_width-1:0] prdata1,
  input  wire  [data_width-1:0] prdata2,
  input  wire  [data_width-1:0] prdata3,
  output slave_sel_t            psel,
  output logic                  penable,
  output logic [addr_width-1:0] paddr,
  output logic                  pwrite,
  output logic [data_width-1:0] pwdata,
  output logic [data_width-1:0] hrdata,
  output logic                  done
);

  apb_state_t            state;
  logic                  pready_sel;
  logic [data_width-1:0] prdata_sel;

  // ---------------------------------------------------------------------------
  // Slave response selection
  // ---------------------------------------------------------------------------

  // Only the selected slave may end the access
  assign pready_sel = |(psel & pready);

  // Masked OR of the read buses, zero when nothing is selected
  always_comb begin
    prdata_sel = `bridge_rst_zero;
    if (psel[0]) begin
      prdata_sel = prdata_sel | prdata0;
    end
    if (psel[1]) begin
      prdata_sel = prdata_sel | prdata1;
    end
    if (psel[2]) begin
      prdata_sel = prdata_sel | prdata2;
    end
    if (psel[3]) begin
      prdata_sel = prdata_sel | prdata3;
    end
  end

  // Access ends on pready, or straight away for an unmapped address
  assign done = (state == apb_access) && (pready_sel || no_hit);

  // Held write data is stable from setup until the next data phase
  assign pwdata = held_wdata;

  // ---------------------------------------------------------------------------
  // Idle / setup / access FSM
  // ---------------------------------------------------------------------------
  always_ff @(posedge hclk6 or negedge hreset_n6) begin
    if (!hreset_n6) begin
      state   <= `bridge_rst_state;
      psel    <= `bridge_rst_zero;
      penable <= 1'b0;
      paddr   <= `bridge_rst_zero;
      pwrite  <= 1'b0;
    end else begin
      case (state)
        apb_idle: begin
          if (pending) begin
            state  <= apb_setup;
            psel   <= slave_sel;
            paddr  <= held_addr;
            pwrite <= held_write;
          end
        end

        apb_setup: begin
          state   <= apb_access;
          // No enable strobe without a selected slave
          penable <= |psel;
        end

        apb_access: begin
          // Waits here while the slave holds pready low
          if (done) begin
            state   <= apb_idle;
            psel    <= `bridge_rst_zero;
            penable <= 1'b0;
          end
        end

        default: begin
          state   <= apb_idle;
          psel    <= `bridge_rst_zero;
          penable <= 1'b0;
        end
      endcase
    end
  end

  // ---------------------------------------------------------------------------
  // AHB read data
  // ---------------------------------------------------------------------------

  // Loaded on the completing edge, also for writes
  always_ff @(posedge hclk6 or negedge hreset_n6) begin
    if (!hreset_n6) begin
      hrdata <= `bridge_rst_zero;
    end else if (done) begin
      hrdata <= prdata_sel;
    end
  end

endmodule

`default_nettype wire

// ==== design/apb_slave_decoder.sv ====
// APB slave address decoder

`timescale 1ns/1ps
`default_nettype none

`include "bridge_regs.svh"

module apb_slave_decoder
  import ahb_apb_pkg::*;
(
  input  wire                  hclk6,
  input  wire                  hreset_n6,
  input  wire                  capture,
  input  wire [addr_width-1:0] haddr,
  output slave_sel_t           slave_sel,
  output logic                 no_hit
);

  // Range hits for the address currently on the bus
  slave_sel_t hit;

  // ---------------------------------------------------------------------------
  // Range compare against the package address map
  // ---------------------------------------------------------------------------
  always_comb begin
    hit = `bridge_rst_zero;
    for (int i = 0; i < num_slaves; i++) begin
      hit[i] = (haddr >= slave_base[i]) && (haddr <= slave_last[i]);
    end
  end

  // ---------------------------------------------------------------------------
  // Select register
  // ---------------------------------------------------------------------------

  // Only loaded on an accepted address phase, held for the whole transfer
  always_ff @(posedge hclk6 or negedge hreset_n6) begin
    if (!hreset_n6) begin
      slave_sel <= `bridge_rst_zero;
      no_hit    <= 1'b0;
    end else if (capture) begin
      slave_sel <= hit;
      // unmapped address, the sequencer completes it without a slave
      no_hit    <= ~|hit;
    end
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+include
design/ahb_apb_pkg.sv
design/ahb_transfer_capture.sv
design/apb_slave_decoder.sv
design/apb_sequencer.sv
design/ahb_apb_bridge.sv
verif/bridge_checker.sv
verif/tb_ahb_apb_bridge.sv

// ==== include/bridge_regs.svh ====
// Bridge register reset macros

`ifndef BRIDGE_REGS_SVH
`define BRIDGE_REGS_SVH

// ---------------------------------------------------------------------------
// Reset values shared by the bridge register blocks
// ---------------------------------------------------------------------------

// Clear value for address, data and select registers
`define bridge_rst_zero '0

// APB FSM comes out of reset idle
`define bridge_rst_state apb_idle

// Level of hready while no transfer is in flight
`define bridge_rst_ready 1'b1

`endif

// ==== verif/bridge_checker.sv ====
// AHB to APB bridge checker

`timescale 1ns/1ps
`default_nettype none

module bridge_checker (
  input  wire        hclk6,
  input  wire        hreset_n6,
  input  wire        hsel,
  input  wire [31:0] haddr,
  input  wire [1:0]  htrans,
  input  wire        hready,
  input  wire [31:0] hrdata,
  input  wire [31:0] paddr,
  input  wire        penable,
  input  wire        pwrite,
  input  wire [31:0] pwdata,
  input  wire [3:0]  psel,
  input  wire [3:0]  pready,
  output int         error_count,
  output logic       finished
);

  logic [31:0] td [0:447];
  int          tests;
  int          failed;
  int          test_errs;

  // Slave select implied by the 4 KB address map
  function automatic logic [3:0] expected_sel(input logic [31:0] addr);
    case (addr[31:12])
      20'h00001: return 4'b0001;
      20'h00002: return 4'b0010;
      20'h00003: return 4'b0100;
      20'h00004: return 4'b1000;
      default:   return 4'b0000;
    endcase
  endfunction

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] test %0d %s = 0x%h, expected 0x%h", tests, name, got, exp);
      test_errs++;
    end
  endtask

  task automatic end_test(input string what);
    if (test_errs == 0) begin
      $display("test %0d %s: pass", tests, what);
    end else begin
      $display("test %0d %s: fail with %0d mismatches", tests, what, test_errs);
      failed++;
      error_count += test_errs;
    end
  endtask

  // ---------------------------------------------------------------------------
  // One accepted transfer sampled mid-cycle from address phase to hready high
  // ---------------------------------------------------------------------------
  task automatic check_transfer(input int b);
    logic [3:0] sel;
    logic       wr;
    logic       rdy;
    int         low;
    int         want;
    sel  = expected_sel(td[b+2]);
    wr   = td[b+3][0];
    want = (sel == 4'b0000) ? 3 : 3 + int'(td[b+5]);
    low  = 0;
    rdy  = 1'b0;
    while (!(hready && hsel && htrans[1] && haddr == td[b+2])) @(negedge hclk6);
    @(negedge hclk6);
    while (!hready) begin
      low++;
      // The selected pready must end the access on the very next edge
      if (rdy) begin
        $display("test %0d: hready still low after the selected pready", tests);
        test_errs++;
      end
      if (low == 1) begin
        compare_value("psel", 32'(psel), 32'd0);
      end else begin
        // Setup at low 2 and access from low 3 on with all bus values held
        compare_value("psel", 32'(psel), 32'(sel));
        compare_value("paddr", paddr, td[b+2]);
        compare_value("pwrite", 32'(pwrite), 32'(wr));
        compare_value("penable", 32'(penable), 32'((low >= 3) && (sel != 4'b0000)));
        if (wr) compare_value("pwdata", pwdata, td[b+4]);
      end
      rdy = |(psel & pready);
      @(negedge hclk6);
    end
    if ((sel != 4'b0000) && !rdy) begin
      $display("test %0d: access ended without the selected pready", tests);
      test_errs++;
    end
    if (low != want) begin
      $display("test %0d: hready was low for %0d cycles instead of %0d", tests, low, want);
      test_errs++;
    end
    compare_value("psel", 32'(psel), 32'd0);
    compare_value("penable", 32'(penable), 32'd0);
    if (!wr) compare_value("hrdata", hrdata, td[b+6]);
  endtask

  // IDLE, BUSY or deselected address phase must leave both buses quiet
  task automatic check_idle(input int b);
    while (!(hready && hsel == td[b][0] && htrans == td[b+1][1:0] && haddr == td[b+2])) begin
      @(negedge hclk6);
    end
    repeat (3) begin
      @(negedge hclk6);
      compare_value("hready", 32'(hready), 32'd1);
      compare_value("psel", 32'(psel), 32'd0);
    end
  endtask

  initial begin
    error_count = 0;
    finished    = 1'b0;
    tests       = 0;
    failed      = 0;
    for (int i = 0; i < 448; i++) begin
      td[i] = '1;
    end
    $readmemh("verif/bridge_testdata.txt", td);
    @(posedge hreset_n6);
    @(negedge hclk6);
    tests++;
    test_errs = 0;
    compare_value("hready", 32'(hready), 32'd1);
    compare_value("psel", 32'(psel), 32'd0);
    compare_value("penable", 32'(penable), 32'd0);
    compare_value("hrdata", hrdata, 32'd0);
    end_test("reset state");
    for (int n = 0; n < 64 && td[7*n] != '1; n++) begin
      tests++;
      test_errs = 0;
      if (td[7*n][0] && td[7*n+1][1]) begin
        check_transfer(7 * n);
        end_test($sformatf("%s 0x%h", td[7*n+3][0] ? "write" : "read", td[7*n+2]));
      end else begin
        check_idle(7 * n);
        end_test($sformatf("no transfer 0x%h", td[7*n+2]));
      end
    end
    $display("%0d tests, %0d passed, %0d failed, %0d mismatches",
             tests, tests - failed, failed, error_count);
    finished = 1'b1;
  end

endmodule

`default_nettype wire

// ==== verif/bridge_testdata.txt ====
// hsel htrans haddr hwrite hwdata waits exp_hrdata, all hex, one line per transfer
// exp_hrdata is only checked on reads
1 2 00001004 1 cafe0001 0 00000000
1 2 00001004 0 00000000 1 cafe0001
1 2 00002008 1 11223344 2 00000000
1 2 00002008 0 00000000 3 11223344
1 2 0000300c 1 a5a55a5a 4 00000000
1 2 0000300c 0 00000000 0 a5a55a5a
1 3 0000403c 1 deadbeef 1 00000000
1 3 0000403c 0 00000000 4 deadbeef
1 2 00002000 0 00000000 2 5a5a2000
1 0 00001010 1 0bad0001 0 00000000 // IDLE
1 1 00002010 1 0bad0002 0 00000000 // BUSY
0 2 00003020 1 0bad0003 0 00000000 // hsel low
1 2 00003020 0 00000000 1 5a5a3020
1 2 00001010 0 00000000 2 5a5a1010
1 2 00008000 0 00000000 0 00000000 // unmapped
1 2 00000ffc 1 12345678 2 00000000 // unmapped
1 2 00005000 0 00000000 3 00000000 // unmapped

// ==== verif/tb_ahb_apb_bridge.sv ====
// AHB to APB bridge testbench

`timescale 1ns/1ps
`default_nettype none

// ---------------------------------------------------------------------------
// APB slave with a 16-word memory and programmable wait states
// ---------------------------------------------------------------------------
module apb_slave_model #(
  parameter logic [31:0] base = 32'h0000_1000
) (
  input  wire         hclk6,
  input  wire         hreset_n6,
  input  wire         psel,
  input  wire         penable,
  input  wire         pwrite,
  input  wire  [31:0] paddr,
  input  wire  [31:0] pwdata,
  input  wire  [31:0] waits,
  output logic        pready,
  output logic [31:0] prdata
);

  logic [31:0] mem [16];
  logic [31:0] count;

  // Ready once the access has lasted the requested number of wait cycles
  assign pready = psel && penable && (count == waits);
  assign prdata = mem[paddr[5:2]];

  always @(posedge hclk6 or negedge hreset_n6) begin
    if (!hreset_n6) begin
      count <= '0;
      // Each word starts as its own byte address with a marker in the upper half
      for (int i = 0; i < 16; i++) begin
        mem[i] <= (base + 32'(i * 4)) ^ 32'h5a5a_0000;
      end
    end else begin
      if (psel && penable && !pready) begin
        count <= count + 32'd1;
      end else begin
        count <= '0;
      end
      if (psel && penable && pready && pwrite) begin
        mem[paddr[5:2]] <= pwdata;
      end
    end
  end

endmodule

module tb_ahb_apb_bridge;

  logic        hclk6 = 1'b0;
  logic        hreset_n6;
  logic        hsel;
  logic [31:0] haddr;
  logic [1:0]  htrans;
  logic        hwrite;
  logic [31:0] hwdata;
  logic [31:0] cur_waits;
  logic        hready;
  logic [31:0] hrdata;
  logic [31:0] paddr;
  logic        penable;
  logic        pwrite;
  logic [31:0] pwdata;
  logic [3:0]  psel;
  logic [3:0]  pready;
  logic [31:0] prdata [4];
  logic [31:0] td [0:447];
  int          lines;
  int          max_wait;
  int          limit = 1000;
  int          cycles = 0;
  integer      seed;
  int          error_count;
  logic        finished;

  always #2 hclk6 = ~hclk6;

  ahb_apb_bridge i_ahb_apb_bridge (
    .hclk6     (hclk6),
    .hreset_n6 (hreset_n6),
    .hsel      (hsel),
    .haddr     (haddr),
    .htrans    (htrans),
    .hwrite    (hwrite),
    .hwdata    (hwdata),
    .hready    (hready),
    .hrdata    (hrdata),
    .paddr     (paddr),
    .penable   (penable),
    .pwrite    (pwrite),
    .pwdata    (pwdata),
    .psel0     (psel[0]),
    .psel1     (psel[1]),
    .psel2     (psel[2]),
    .psel3     (psel[3]),
    .pready0   (pready[0]),
    .pready1   (pready[1]),
    .pready2   (pready[2]),
    .pready3   (pready[3]),
    .prdata0   (prdata[0]),
    .prdata1   (prdata[1]),
    .prdata2   (prdata[2]),
    .prdata3   (prdata[3])
  );

  // One slave per 4 KB page, starting at 0x1000
  for (genvar s = 0; s < 4; s++) begin : g_slave
    apb_slave_model #(.base(32'(s + 1) << 12)) i_apb_slave_model (
      .hclk6 (hclk6), .hreset_n6 (hreset_n6), .psel (psel[s]), .penable (penable),
      .pwrite (pwrite), .paddr (paddr), .pwdata (pwdata), .waits (cur_waits),
      .pready (pready[s]), .prdata (prdata[s])
    );
  end

  bridge_checker i_bridge_checker (
    .hclk6 (hclk6), .hreset_n6 (hreset_n6), .hsel (hsel), .haddr (haddr),
    .htrans (htrans), .hready (hready), .hrdata (hrdata), .paddr (paddr),
    .penable (penable), .pwrite (pwrite), .pwdata (pwdata), .psel (psel),
    .pready (pready), .error_count (error_count), .finished (finished)
  );

  // ---------------------------------------------------------------------------
  // AHB master driver, one data line per call
  // ---------------------------------------------------------------------------
  task automatic drive_line(input int b);
    int gap;
    while (!hready) begin
      @(posedge hclk6);
      #1;
    end
    gap = $unsigned($random(seed)) % 4;
    repeat (gap) begin
      @(posedge hclk6);
      #1;
    end
    hsel      = td[b][0];
    htrans    = td[b+1][1:0];
    haddr     = td[b+2];
    hwrite    = td[b+3][0];
    cur_waits = td[b+5];
    @(posedge hclk6);
    #1;
    // Data phase follows the address phase
    hsel   = 1'b0;
    htrans = 2'b00;
    haddr  = '0;
    hwrite = 1'b0;
    hwdata = td[b+4];
    @(posedge hclk6);
    #1;
    hwdata = '0;
    // Quiet bus after a line that must not start a transfer
    if (!(td[b][0] && td[b+1][1])) begin
      repeat (2) begin
        @(posedge hclk6);
        #1;
      end
    end
  endtask

  always @(posedge hclk6) begin
    cycles <= cycles + 1;
    if (cycles > limit) begin
      $display("Timeout: run still busy after %0d cycles", cycles);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  initial begin
    hreset_n6 = 1'b0;
    hsel      = 1'b0;
    haddr     = '0;
    htrans    = 2'b00;
    hwrite    = 1'b0;
    hwdata    = '0;
    cur_waits = '0;
    seed      = 20;
    for (int i = 0; i < 448; i++) begin
      td[i] = '1;
    end
    $readmemh("verif/bridge_testdata.txt", td);
    lines    = 0;
    max_wait = 0;
    while (lines < 64 && td[7*lines] != '1) begin
      if (int'(td[7*lines+5]) > max_wait) begin
        max_wait = int'(td[7*lines+5]);
      end
      lines++;
    end
    limit = lines * (3 + max_wait + 2) + 50;
    repeat (3) @(posedge hclk6);
    #1;
    hreset_n6 = 1'b1;
    repeat (2) begin
      @(posedge hclk6);
      #1;
    end
    for (int n = 0; n < lines; n++) begin
      drive_line(7 * n);
    end
    wait (finished);
    if (error_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire
